//--- source/lsu_pkg.sv
package lsu_pkg;

  // Data and address word.
  typedef logic [31:0] word_t;

  // One strobe bit per byte lane.
  typedef logic [3:0] strb_t;

  // Access size of a core request.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_t;

  // Response code on the read data and write response channels.
  typedef enum logic {
    RESP_OKAY   = 1'b0,
    RESP_SLVERR = 1'b1
  } resp_t;

  // Completion status reported to the core.
  typedef enum logic [1:0] {
    FAULT_NONE       = 2'd0,
    FAULT_MISALIGNED = 2'd1,
    FAULT_BUS        = 2'd2
  } fault_t;

endpackage

//--- source/lsu_align.sv
module lsu_align (
  input  lsu_pkg::size_t size,
  input  logic           sext,
  input  logic [1:0]     addr_low,
  input  lsu_pkg::word_t wdata,
  output lsu_pkg::word_t store_data,
  output lsu_pkg::strb_t store_strb,
  output logic           misaligned,
  input  lsu_pkg::word_t load_word,
  output lsu_pkg::word_t load_data
);

  import lsu_pkg::*;

  logic [4:0] shift;
  word_t      lane;

  // Bit offset of the addressed byte within the word.
  assign shift = {addr_low, 3'b000};

  // Addressed byte or halfword moved down to bit 0.
  assign lane = load_word >> shift;

  always_comb begin
    case (size)
      SIZE_BYTE: begin
        misaligned = 1'b0;
        store_strb = strb_t'(4'b0001 << addr_low);
        store_data = {24'b0, wdata[7:0]} << shift;
        load_data  = {{24{sext & lane[7]}}, lane[7:0]};
      end
      SIZE_HALF: begin
        // Halfwords sit on even addresses.
        misaligned = addr_low[0];
        store_strb = strb_t'(4'b0011 << addr_low);
        store_data = {16'b0, wdata[15:0]} << shift;
        load_data  = {{16{sext & lane[15]}}, lane[15:0]};
      end
      default: begin
        misaligned = addr_low != 2'b00;
        store_strb = 4'b1111;
        store_data = wdata;
        load_data  = load_word;
      end
    endcase
  end

endmodule

//--- source/lsu.sv
module lsu (
  input  logic           clk,
  input  logic           rst,
  // Core side.
  input  logic           req,
  output logic           ready,
  input  logic           we,
  input  lsu_pkg::size_t size,
  input  logic           sext,
  input  lsu_pkg::word_t addr,
  input  lsu_pkg::word_t wdata,
  output logic           done,
  output lsu_pkg::word_t rdata,
  output lsu_pkg::fault_t fault,
  // Read address channel.
  output lsu_pkg::word_t araddr,
  output logic           arvalid,
  input  logic           arready,
  // Read data channel.
  input  lsu_pkg::word_t rdata_bus,
  input  lsu_pkg::resp_t rresp,
  input  logic           rvalid,
  output logic           rready,
  // Write address channel.
  output lsu_pkg::word_t awaddr,
  output logic           awvalid,
  input  logic           awready,
  // Write data channel.
  output lsu_pkg::word_t wdata_bus,
  output lsu_pkg::strb_t wstrb,
  output logic           wvalid,
  input  logic           wready,
  // Write response channel.
  input  lsu_pkg::resp_t bresp,
  input  logic           bvalid,
  output logic           bready
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_check,
    s_raddr,
    s_rdata,
    s_waddr,
    s_wdata,
    s_wresp
  } state_t;

  state_t state;

  // Request as taken from the core.
  logic  req_we;
  size_t req_size;
  logic  req_sext;
  word_t req_addr;
  word_t req_wdata;

  logic  misaligned;
  word_t load_data;
  logic  start_read;
  logic  start_write;

  lsu_align lsu_align_inst (
    .size       (req_size),
    .sext       (req_sext),
    .addr_low   (req_addr[1:0]),
    .wdata      (req_wdata),
    .store_data (wdata_bus),
    .store_strb (wstrb),
    .misaligned (misaligned),
    .load_word  (rdata_bus),
    .load_data  (load_data)
  );

  // Address valid goes up straight out of the check state.
  assign start_read  = (state == s_check) && !misaligned && !req_we;
  assign start_write = (state == s_check) && !misaligned && req_we;

  assign ready   = state == s_idle;
  assign arvalid = start_read || (state == s_raddr);
  assign awvalid = start_write || (state == s_waddr);
  assign wvalid  = state == s_wdata;
  assign araddr  = req_addr;
  assign awaddr  = req_addr;

  // Only one access in flight, so a response always has room.
  assign rready = 1'b1;
  assign bready = 1'b1;

  always_ff @(posedge clk) begin
    if (req && ready) begin
      req_we    <= we;
      req_size  <= size;
      req_sext  <= sext;
      req_addr  <= addr;
      req_wdata <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      done  <= 1'b0;
      fault <= FAULT_NONE;
    end else begin
      done <= 1'b0;
      case (state)
        s_idle: begin
          if (req) begin
            state <= s_check;
          end
        end
        s_check: begin
          if (misaligned) begin
            done  <= 1'b1;
            fault <= FAULT_MISALIGNED;
            state <= s_idle;
          end else if (req_we) begin
            state <= awready ? s_wdata : s_waddr;
          end else begin
            state <= arready ? s_rdata : s_raddr;
          end
        end
        s_raddr: begin
          if (arready) begin
            state <= s_rdata;
          end
        end
        s_rdata: begin
          if (rvalid && rready) begin
            done  <= 1'b1;
            fault <= (rresp == RESP_SLVERR) ? FAULT_BUS : FAULT_NONE;
            state <= s_idle;
          end
        end
        s_waddr: begin
          if (awready) begin
            state <= s_wdata;
          end
        end
        s_wdata: begin
          if (wready) begin
            state <= s_wresp;
          end
        end
        s_wresp: begin
          if (bvalid && bready) begin
            done  <= 1'b1;
            fault <= (bresp == RESP_SLVERR) ? FAULT_BUS : FAULT_NONE;
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // Load result, cleared on an error response.
  always_ff @(posedge clk) begin
    if (state == s_rdata && rvalid && rready) begin
      rdata <= (rresp == RESP_OKAY) ? load_data : '0;
    end
  end

endmodule

//--- source/axi_lite_sram.sv
module axi_lite_sram #(
  parameter int mem_words     = 1024,
  parameter int read_latency  = 2,
  parameter int write_latency = 1
) (
  input  logic           clk,
  input  logic           rst,
  // Read address channel.
  input  lsu_pkg::word_t araddr,
  input  logic           arvalid,
  output logic           arready,
  // Read data channel.
  output lsu_pkg::word_t rdata,
  output lsu_pkg::resp_t rresp,
  output logic           rvalid,
  input  logic           rready,
  // Write address channel.
  input  lsu_pkg::word_t awaddr,
  input  logic           awvalid,
  output logic           awready,
  // Write data channel.
  input  lsu_pkg::word_t wdata,
  input  lsu_pkg::strb_t wstrb,
  input  logic           wvalid,
  output logic           wready,
  // Write response channel.
  output lsu_pkg::resp_t bresp,
  output logic           bvalid,
  input  logic           bready
);

  import lsu_pkg::*;

  localparam int addr_bits = $clog2(mem_words);
  localparam int rcnt_bits = $clog2(read_latency + 1);
  localparam int wcnt_bits = $clog2(write_latency + 1);

  typedef enum logic {
    r_idle,
    r_busy
  } rstate_t;

  typedef enum logic [1:0] {
    w_idle,
    w_data,
    w_resp
  } wstate_t;

  word_t mem [mem_words];

  rstate_t              rstate;
  logic [rcnt_bits-1:0] rcnt;
  wstate_t              wstate;
  logic [wcnt_bits-1:0] wcnt;
  word_t                waddr_q;

  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_in_range;
  logic w_in_range;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  // Word index has to fall below the depth.
  assign ar_in_range = (araddr >> 2) < word_t'(mem_words);
  assign w_in_range  = (waddr_q >> 2) < word_t'(mem_words);

  assign arready = rstate == r_idle;
  assign rvalid  = (rstate == r_busy) && (rcnt == '0);
  assign awready = wstate == w_idle;
  assign wready  = wstate == w_data;
  assign bvalid  = (wstate == w_resp) && (wcnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      rstate <= r_idle;
      rcnt   <= '0;
    end else begin
      case (rstate)
        r_idle: begin
          if (ar_fire) begin
            rstate <= r_busy;
            rcnt   <= rcnt_bits'(read_latency - 1);
          end
        end
        default: begin
          if (rcnt != '0) begin
            rcnt <= rcnt - rcnt_bits'(1);
          end else if (r_fire) begin
            rstate <= r_idle;
          end
        end
      endcase
    end
  end

  // Read word is sampled when the address is taken.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (ar_in_range) begin
        rdata <= mem[araddr[addr_bits+1:2]];
        rresp <= RESP_OKAY;
      end else begin
        rdata <= '0;
        rresp <= RESP_SLVERR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wstate <= w_idle;
      wcnt   <= '0;
    end else begin
      case (wstate)
        w_idle: begin
          if (aw_fire) begin
            wstate <= w_data;
          end
        end
        w_data: begin
          if (w_fire) begin
            wstate <= w_resp;
            wcnt   <= wcnt_bits'(write_latency - 1);
          end
        end
        default: begin
          if (wcnt != '0) begin
            wcnt <= wcnt - wcnt_bits'(1);
          end else if (b_fire) begin
            wstate <= w_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      waddr_q <= awaddr;
    end
    if (w_fire) begin
      bresp <= w_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Only strobed lanes change.
  always_ff @(posedge clk) begin
    if (w_fire && w_in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[waddr_q[addr_bits+1:2]][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- source/mem_subsystem.sv
module mem_subsystem #(
  parameter int mem_words     = 1024,
  parameter int read_latency  = 2,
  parameter int write_latency = 1
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  output logic            ready,
  input  logic            we,
  input  lsu_pkg::size_t  size,
  input  logic            sext,
  input  lsu_pkg::word_t  addr,
  input  lsu_pkg::word_t  wdata,
  output logic            done,
  output lsu_pkg::word_t  rdata,
  output lsu_pkg::fault_t fault
);

  import lsu_pkg::*;

  word_t araddr;
  logic  arvalid;
  logic  arready;
  word_t bus_rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;
  word_t awaddr;
  logic  awvalid;
  logic  awready;
  word_t bus_wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;

  lsu lsu_inst (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ready     (ready),
    .we        (we),
    .size      (size),
    .sext      (sext),
    .addr      (addr),
    .wdata     (wdata),
    .done      (done),
    .rdata     (rdata),
    .fault     (fault),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata_bus (bus_rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_bus (bus_wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  axi_lite_sram #(
    .mem_words     (mem_words),
    .read_latency  (read_latency),
    .write_latency (write_latency)
  ) axi_lite_sram_inst (
    .clk     (clk),
    .rst     (rst),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (bus_rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (bus_wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

//--- tb/mem_subsystem_tb.sv
module mem_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int mem_words     = 1024;
  localparam int read_latency  = 2;
  localparam int write_latency = 1;
  localparam int reset_cycles  = 10;

  typedef struct {
    logic   we;
    size_t  size;
    logic   sext;
    word_t  addr;
    word_t  wdata;
    word_t  exp_data;
    fault_t exp_fault;
  } vec_t;

  logic   clk;
  logic   rst;
  logic   req;
  logic   ready;
  logic   we;
  size_t  size;
  logic   sext;
  word_t  addr;
  word_t  wdata;
  logic   done;
  word_t  rdata;
  fault_t fault;

  vec_t       vecs[$];
  logic [7:0] lfsr;
  int         errors;
  int         checks;
  int         accepted;
  int         done_count;
  int         cycle_count;
  int         timeout_limit;

  mem_subsystem #(
    .mem_words     (mem_words),
    .read_latency  (read_latency),
    .write_latency (write_latency)
  ) mem_subsystem_inst (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .ready (ready),
    .we    (we),
    .size  (size),
    .sext  (sext),
    .addr  (addr),
    .wdata (wdata),
    .done  (done),
    .rdata (rdata),
    .fault (fault)
  );

  always #10 clk = ~clk;

  // Completion pulses seen on the core side.
  always @(posedge clk) begin
    if (!rst && done) begin
      done_count <= done_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the DUT stalled, no completion within %0d cycles", timeout_limit);
      $display("sim failed");
      $finish;
    end
  end

  // Taps 8, 6, 5, 4.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic size_t decode_size(input int code);
    case (code)
      0:       return SIZE_BYTE;
      1:       return SIZE_HALF;
      default: return SIZE_WORD;
    endcase
  endfunction

  function automatic fault_t decode_fault(input int code);
    case (code)
      0:       return FAULT_NONE;
      1:       return FAULT_MISALIGNED;
      default: return FAULT_BUS;
    endcase
  endfunction

  task automatic draw_gap(output logic [1:0] gap);
    gap[0] = lfsr[7];
    lfsr = lfsr_next(lfsr);
    gap[1] = lfsr[7];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic check_data(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_fault(input string name, input fault_t got, input fault_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    int    op_i;
    int    size_i;
    int    sext_i;
    int    fault_i;
    word_t a;
    word_t wd;
    word_t ed;
    string line;
    vec_t  v;
    fd = $fopen("tb/lsu_tests.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %h %h %h %d", op_i, size_i, sext_i, a, wd, ed, fault_i);
      if (n != 7) begin
        errors++;
        $display("Malformed test vector line: %s", line);
        continue;
      end
      v.we        = op_i != 0;
      v.size      = decode_size(size_i);
      v.sext      = sext_i != 0;
      v.addr      = a;
      v.wdata     = wd;
      v.exp_data  = ed;
      v.exp_fault = decode_fault(fault_i);
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // Puts a request on the core side, where it stays until it is taken.
  task automatic drive_request(input vec_t v);
    req   <= 1'b1;
    we    <= v.we;
    size  <= v.size;
    sext  <= v.sext;
    addr  <= v.addr;
    wdata <= v.wdata;
  endtask

  // Starts on a rising edge and returns on the edge where done is seen.
  // With hold_next the following request goes up at once and waits while this one runs.
  task automatic run_access(input int idx, input logic hold_next);
    int   errors_before;
    logic busy_ready;
    vec_t v;
    errors_before = errors;
    busy_ready    = 1'b0;
    v             = vecs[idx];
    // A held request may already have been taken on this edge.
    while (!(req && ready)) begin
      @(posedge clk);
    end
    accepted++;
    if (hold_next) begin
      drive_request(vecs[idx + 1]);
    end else begin
      req <= 1'b0;
    end
    @(posedge clk);
    while (!done) begin
      if (ready && !busy_ready) begin
        busy_ready = 1'b1;
        errors++;
        $display("Ready went high at %0t ns while test %0d was still in flight", $time, idx);
      end
      @(posedge clk);
    end
    check_fault("fault", fault, v.exp_fault);
    // Load data means nothing once the access faulted.
    if (!v.we && v.exp_fault == FAULT_NONE) begin
      check_data("rdata", rdata, v.exp_data);
    end
    $display("test %0d: %s %s at %h, %s", idx, v.we ? "store" : "load", v.size.name(),
             v.addr, (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin
    logic [1:0] gap;
    clk           = 1'b0;
    lfsr          = 8'd53;
    errors        = 0;
    checks        = 0;
    accepted      = 0;
    timeout_limit = 0;
    rst         <= 1'b1;
    req         <= 1'b0;
    we          <= 1'b0;
    size        <= SIZE_BYTE;
    sext        <= 1'b0;
    addr        <= '0;
    wdata       <= '0;
    done_count  <= 0;
    cycle_count <= 0;
    load_vectors();
    if (vecs.size() == 0) begin
      $display("No test vectors could be read from tb/lsu_tests.txt");
      $display("sim failed");
      $finish;
    end else begin
      timeout_limit = vecs.size() * (read_latency + write_latency + 10) + reset_cycles + 20;
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      if (!ready || done) begin
        errors++;
        $display("After reset ready was low or done was high");
      end
      draw_gap(gap);
      foreach (vecs[i]) begin
        // With no gap the request is already up from the access before.
        if (i == 0 || gap != 2'd0) begin
          repeat (gap) @(posedge clk);
          drive_request(vecs[i]);
        end
        if (i + 1 < vecs.size()) begin
          draw_gap(gap);
        end
        run_access(i, (gap == 2'd0) && (i + 1 < vecs.size()));
      end
      // A few idle cycles to catch any stray done.
      repeat (3) @(posedge clk);
      if (done_count != accepted) begin
        errors++;
        $display("Saw %0d done pulses for %0d accepted requests", done_count, accepted);
      end
      $display("%0d tests, %0d checks, %0d errors", vecs.size(), checks, errors);
      if (errors == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

//--- tb/lsu_tests.txt
# op (0 load, 1 store) size (0 byte, 1 half, 2 word) sext addr wdata rdata_expected
# fault_expected (0 none, 1 misaligned, 2 bus); rdata is ignored for stores and faults
1 2 0 00000000 deadbeef 00000000 0
0 2 0 00000000 00000000 deadbeef 0
1 2 0 00000ffc 12345678 00000000 0
0 2 0 00000ffc 00000000 12345678 0
1 2 0 00000010 11223344 00000000 0
1 0 0 00000011 000000aa 00000000 0
0 2 0 00000010 00000000 1122aa44 0
1 0 0 00000013 000000bb 00000000 0
0 2 0 00000010 00000000 bb22aa44 0
1 1 0 00000012 9999cdef 00000000 0
0 2 0 00000010 00000000 cdefaa44 0
1 0 0 00000010 ffffff5a 00000000 0
0 2 0 00000010 00000000 cdefaa5a 0
1 1 0 00000010 00001234 00000000 0
0 2 0 00000010 00000000 cdef1234 0
1 0 0 00000012 00000077 00000000 0
0 2 0 00000010 00000000 cd771234 0
1 2 0 00000020 80f07f85 00000000 0
0 0 0 00000020 00000000 00000085 0
0 0 1 00000020 00000000 ffffff85 0
0 0 1 00000021 00000000 0000007f 0
0 0 0 00000022 00000000 000000f0 0
0 0 1 00000022 00000000 fffffff0 0
0 0 0 00000023 00000000 00000080 0
0 0 1 00000023 00000000 ffffff80 0
0 1 0 00000020 00000000 00007f85 0
0 1 1 00000020 00000000 00007f85 0
0 1 0 00000022 00000000 000080f0 0
0 1 1 00000022 00000000 ffff80f0 0
1 2 0 00000030 a5a5a5a5 00000000 0
1 1 0 00000031 0000ffff 00000000 1
1 2 0 00000032 00000000 00000000 1
1 2 0 00000031 00000000 00000000 1
1 1 0 00000033 00000000 00000000 1
0 1 0 00000031 00000000 00000000 1
0 2 1 00000033 00000000 00000000 1
0 2 0 00000030 00000000 a5a5a5a5 0
0 0 0 00000031 00000000 000000a5 0
1 2 0 00001000 cafef00d 00000000 2
0 2 0 00001000 00000000 00000000 2
1 0 0 00001003 00000011 00000000 2
0 1 1 fffffffe 00000000 00000000 2
0 2 0 00000000 00000000 deadbeef 0

//--- src.f
source/lsu_pkg.sv
source/lsu_align.sv
source/lsu.sv
source/axi_lite_sram.sv
source/mem_subsystem.sv
tb/mem_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TESTS     ?= tb/lsu_tests.txt
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY) $(TESTS)
	./$(BINARY) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
